// File: fix_cfg.svh
`ifndef FIX_CFG_SVH
`define FIX_CFG_SVH

// remote hosts sharing the link, one session unit each
`define FIX_NUM_HOST 4

// host id width, log2 of the host count
`define FIX_HOST_W 2

// idle clock cycles of an active session before it sends a heartbeat
`define FIX_HB_CYCLES 300

// field separator
`define FIX_SOH 8'h01

// ascii characters used by the parser and the composer
`define FIX_CHR_EQ 8'h3d
`define FIX_CHR_ZERO 8'h30

// tag numbers that the engine looks at
`define FIX_TAG_MSGTYPE 10'd35
`define FIX_TAG_CHECKSUM 10'd10

`endif

// File: fix_pkg.sv
`default_nettype none

`include "fix_cfg.svh"

package fix_pkg;

	// message type, kept as the ascii character of tag 35
	typedef enum logic [7:0] {
		FIX_MT_HEARTBEAT = 8'h30,	// '0'
		FIX_MT_TEST_REQ  = 8'h31,	// '1'
		FIX_MT_LOGOUT    = 8'h35,	// '5'
		FIX_MT_LOGON     = 8'h41	// 'A'
	} fix_msg_type_e;

	// one finished incoming message, reported by the parser
	typedef struct packed {
		logic [`FIX_HOST_W-1:0] host;	// sender of the message
		fix_msg_type_e          msg_type;	// first value byte of tag 35
		logic                   chk_ok;	// tag 10 matched the byte sum
		logic                   type_seen;	// tag 35 was present
	} fix_rx_msg_t;

	// request of one session towards the composer
	typedef struct packed {
		logic          req;	// level, held until sent
		fix_msg_type_e msg_type;
		logic [11:0]   seq_bcd;	// three bcd digits, msd first
	} fix_tx_req_t;

endpackage

`default_nettype wire

// File: fix_rx_parser.sv
`timescale 1ns/1ns
`default_nettype none

`include "fix_cfg.svh"

module fix_rx_parser
	import fix_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   rst_n_i,
	input  wire logic                   rx_valid_i,
	input  wire logic [7:0]             rx_byte_i,
	input  wire logic [`FIX_HOST_W-1:0] rx_host_i,
	output logic                        msg_valid_o,
	output fix_rx_msg_t                 msg_o
);

	typedef enum logic {
		PS_TAG,
		PS_VAL
	} pstate_e;

	pstate_e                state_q;
	logic                   in_msg_q;	// a message has started
	logic [`FIX_HOST_W-1:0] host_q;
	logic [9:0]             tag_q;	// decimal tag number so far
	logic                   val_first_q;	// next value byte is the first one
	logic [7:0]             sum_q;	// running byte sum of the message
	logic [7:0]             pre_sum_q;	// sum before the current field
	logic [9:0]             chk_val_q;	// decimal value of tag 10
	fix_msg_type_e          type_q;
	logic                   type_seen_q;

	logic [7:0]             sum_cur;
	logic [7:0]             sum_nxt;
	logic                   is_soh;
	logic                   is_eq;
	logic                   msg_done;

	// a new message starts its sum from zero
	assign sum_cur  = in_msg_q ? sum_q : 8'h00;
	assign sum_nxt  = sum_cur + rx_byte_i;
	assign is_soh   = (rx_byte_i == `FIX_SOH);
	assign is_eq    = (rx_byte_i == `FIX_CHR_EQ);
	assign msg_done = rx_valid_i && (state_q == PS_VAL) && is_soh &&
		(tag_q == `FIX_TAG_CHECKSUM);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= PS_TAG;
			in_msg_q    <= 1'b0;
			host_q      <= '0;
			tag_q       <= '0;
			val_first_q <= 1'b0;
			sum_q       <= '0;
			pre_sum_q   <= '0;
			chk_val_q   <= '0;
			type_q      <= FIX_MT_HEARTBEAT;
			type_seen_q <= 1'b0;
			msg_valid_o <= 1'b0;
		end else begin
			msg_valid_o <= msg_done;
			if (rx_valid_i) begin
				sum_q    <= sum_nxt;
				in_msg_q <= 1'b1;
				if (!in_msg_q) begin
					host_q      <= rx_host_i;	// sampled with the first byte
					type_seen_q <= 1'b0;
					pre_sum_q   <= '0;
				end
				case (state_q)
					PS_TAG: begin
						if (is_eq) begin
							state_q     <= PS_VAL;
							val_first_q <= 1'b1;
							chk_val_q   <= '0;
						end else if (is_soh) begin
							tag_q     <= '0;	// empty field, skip it
							pre_sum_q <= sum_nxt;
						end else begin
							tag_q <= 10'(tag_q * 10 + rx_byte_i[3:0]);
						end
					end
					PS_VAL: begin
						val_first_q <= 1'b0;
						if (is_soh) begin
							state_q   <= PS_TAG;
							tag_q     <= '0;
							pre_sum_q <= sum_nxt;	// sum up to the next field start
							if (tag_q == `FIX_TAG_CHECKSUM)
								in_msg_q <= 1'b0;
						end else if (tag_q == `FIX_TAG_MSGTYPE && val_first_q) begin
							type_q      <= fix_msg_type_e'(rx_byte_i);
							type_seen_q <= 1'b1;
						end else if (tag_q == `FIX_TAG_CHECKSUM) begin
							chk_val_q <= 10'(chk_val_q * 10 + rx_byte_i[3:0]);
						end
					end
					default: state_q <= PS_TAG;
				endcase
			end
		end
	end

	// report registered on the closing soh
	always_ff @(posedge clk) begin
		if (msg_done) begin
			msg_o.host      <= host_q;
			msg_o.msg_type  <= type_q;
			msg_o.chk_ok    <= ({2'b00, pre_sum_q} == chk_val_q);
			msg_o.type_seen <= type_seen_q;
		end
	end

endmodule

`default_nettype wire

// File: fix_session.sv
`timescale 1ns/1ns
`default_nettype none

`include "fix_cfg.svh"

module fix_session
	import fix_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n_i,
	input  wire logic  rx_valid_i,	// already matched to this host
	input  wire fix_rx_msg_t rx_msg_i,
	input  wire logic  connect_i,
	input  wire logic  end_session_i,
	input  wire logic  sent_i,
	output fix_tx_req_t tx_req_o,
	output logic       active_o
);

	localparam int HB_W = $clog2(`FIX_HB_CYCLES + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_AWAIT,	// logon sent and waiting for the peer logon
		ST_ACTIVE,
		ST_CLOSING	// logout queued until it is sent
	} sstate_e;

	sstate_e          state_q;
	sstate_e          state_d;
	logic [HB_W-1:0]  hb_cnt_q;
	logic             rx_hit;
	logic             trig;
	fix_msg_type_e    trig_type;
	logic             accept;

	function automatic logic [11:0] bcd_inc(input logic [11:0] v);
		logic [11:0] r;
		r = v;
		if (r[3:0] != 4'd9) begin
			r[3:0] = r[3:0] + 4'd1;
		end else begin
			r[3:0] = 4'd0;
			if (r[7:4] != 4'd9) begin
				r[7:4] = r[7:4] + 4'd1;
			end else begin
				r[7:4]  = 4'd0;
				r[11:8] = (r[11:8] == 4'd9) ? 4'd0 : r[11:8] + 4'd1;	// 999 wraps to 000
			end
		end
		return r;
	endfunction

	// bad checksum or missing type is dropped here
	assign rx_hit   = rx_valid_i && rx_msg_i.chk_ok && rx_msg_i.type_seen;
	assign active_o = (state_q == ST_ACTIVE);

	always_comb begin
		state_d   = state_q;
		trig      = 1'b0;
		trig_type = FIX_MT_HEARTBEAT;
		case (state_q)
			ST_IDLE: begin
				if (connect_i) begin
					trig      = 1'b1;
					trig_type = FIX_MT_LOGON;
					state_d   = ST_AWAIT;
				end
			end
			ST_AWAIT: begin
				if (rx_hit && rx_msg_i.msg_type == FIX_MT_LOGON)
					state_d = ST_ACTIVE;
			end
			ST_ACTIVE: begin
				if (end_session_i || (rx_hit && rx_msg_i.msg_type == FIX_MT_LOGOUT)) begin
					trig      = 1'b1;
					trig_type = FIX_MT_LOGOUT;
					state_d   = ST_CLOSING;
				end else if (rx_hit && rx_msg_i.msg_type == FIX_MT_TEST_REQ) begin
					trig = 1'b1;	// answer with a heartbeat
				end else if (hb_cnt_q == HB_W'(`FIX_HB_CYCLES)) begin
					trig = 1'b1;
				end
			end
			ST_CLOSING: begin
				if (sent_i && tx_req_o.msg_type == FIX_MT_LOGOUT) begin
					state_d = ST_IDLE;
				end else if (!tx_req_o.req) begin
					trig      = 1'b1;	// logout was dropped behind another request
					trig_type = FIX_MT_LOGOUT;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	// pending request blocks new ones except a logout over a heartbeat
	assign accept = trig && (!tx_req_o.req || sent_i ||
		(trig_type == FIX_MT_LOGOUT && tx_req_o.msg_type == FIX_MT_HEARTBEAT));

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q           <= ST_IDLE;
			hb_cnt_q          <= '0;
			tx_req_o.req      <= 1'b0;
			tx_req_o.msg_type <= FIX_MT_HEARTBEAT;
			tx_req_o.seq_bcd  <= 12'h001;
		end else begin
			state_q <= state_d;

			if (state_q != ST_ACTIVE || rx_hit || sent_i ||
				hb_cnt_q == HB_W'(`FIX_HB_CYCLES))
				hb_cnt_q <= '0;
			else
				hb_cnt_q <= hb_cnt_q + 1'b1;

			if (sent_i) begin
				tx_req_o.seq_bcd <= bcd_inc(tx_req_o.seq_bcd);
				tx_req_o.req     <= 1'b0;
			end
			if (accept) begin
				tx_req_o.req      <= 1'b1;
				tx_req_o.msg_type <= trig_type;
			end
		end
	end

endmodule

`default_nettype wire

// File: fix_tx_composer.sv
`timescale 1ns/1ns
`default_nettype none

`include "fix_cfg.svh"

module fix_tx_composer
	import fix_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   rst_n_i,
	input  wire fix_tx_req_t            req_i [`FIX_NUM_HOST],
	input  wire logic                   fifo_full_i,
	output logic                        sent_o [`FIX_NUM_HOST],
	output logic                        fifo_write_o,
	output logic [7:0]                  fifo_data_o,
	output logic [`FIX_HOST_W-1:0]      fifo_host_o,
	output logic                        msg_end_o
);

	localparam int HW       = `FIX_HOST_W;
	localparam int LAST_IDX = 18;	// 19 bytes per message
	localparam int SUM_IDX  = 11;	// checksum covers bytes 0 to 11

	logic           busy_q;
	logic [HW-1:0]  host_q;	// host being served
	logic [HW-1:0]  last_q;	// last host served
	fix_msg_type_e  type_q;
	logic [11:0]    seq_q;
	logic [4:0]     idx_q;
	logic [7:0]     sum_q;

	logic           grant_vld;
	logic [HW-1:0]  grant_id;
	logic [7:0]     byte_d;
	logic [3:0]     chk_hun;
	logic [3:0]     chk_ten;
	logic [3:0]     chk_one;

	// round robin starting after the last host served
	always_comb begin
		logic [HW-1:0] cand;
		grant_vld = 1'b0;
		grant_id  = last_q;
		for (int k = 1; k <= `FIX_NUM_HOST; k++) begin
			cand = HW'((int'(last_q) + k) % `FIX_NUM_HOST);
			if (!grant_vld && req_i[cand].req) begin
				grant_vld = 1'b1;
				grant_id  = cand;
			end
		end
	end

	assign chk_hun = 4'(sum_q / 8'd100);
	assign chk_ten = 4'((sum_q / 8'd10) % 8'd10);
	assign chk_one = 4'(sum_q % 8'd10);

	// "35=T" soh "34=DDD" soh "10=CCC" soh
	always_comb begin
		case (idx_q)
			5'd0:    byte_d = 8'h33;
			5'd1:    byte_d = 8'h35;
			5'd2:    byte_d = `FIX_CHR_EQ;
			5'd3:    byte_d = type_q;
			5'd4:    byte_d = `FIX_SOH;
			5'd5:    byte_d = 8'h33;
			5'd6:    byte_d = 8'h34;
			5'd7:    byte_d = `FIX_CHR_EQ;
			5'd8:    byte_d = {4'h3, seq_q[11:8]};
			5'd9:    byte_d = {4'h3, seq_q[7:4]};
			5'd10:   byte_d = {4'h3, seq_q[3:0]};
			5'd11:   byte_d = `FIX_SOH;
			5'd12:   byte_d = 8'h31;
			5'd13:   byte_d = 8'h30;
			5'd14:   byte_d = `FIX_CHR_EQ;
			5'd15:   byte_d = `FIX_CHR_ZERO + chk_hun;
			5'd16:   byte_d = `FIX_CHR_ZERO + chk_ten;
			5'd17:   byte_d = `FIX_CHR_ZERO + chk_one;
			default: byte_d = `FIX_SOH;
		endcase
	end

	assign fifo_write_o = busy_q && !fifo_full_i;	// full fifo holds the byte
	assign fifo_data_o  = byte_d;
	assign fifo_host_o  = host_q;
	assign msg_end_o    = fifo_write_o && (idx_q == 5'(LAST_IDX));

	always_comb begin
		for (int i = 0; i < `FIX_NUM_HOST; i++)
			sent_o[i] = msg_end_o && (host_q == HW'(i));
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			last_q <= HW'(`FIX_NUM_HOST - 1);	// host 0 goes first
			idx_q  <= '0;
			sum_q  <= '0;
		end else if (!busy_q) begin
			if (grant_vld) begin
				busy_q <= 1'b1;
				idx_q  <= '0;
				sum_q  <= '0;
			end
		end else if (fifo_write_o) begin
			idx_q <= idx_q + 1'b1;
			if (idx_q <= 5'(SUM_IDX))
				sum_q <= sum_q + byte_d;
			if (msg_end_o) begin
				busy_q <= 1'b0;
				last_q <= host_q;
			end
		end
	end

	// latched request fields
	always_ff @(posedge clk) begin
		if (!busy_q && grant_vld) begin
			host_q <= grant_id;
			type_q <= req_i[grant_id].msg_type;
			seq_q  <= req_i[grant_id].seq_bcd;
		end
	end

endmodule

`default_nettype wire

// File: fix_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "fix_cfg.svh"

module fix_engine
	import fix_pkg::*;
(
	input  wire logic                    clk,
	input  wire logic                    rst_n_i,
	input  wire logic                    connect_i,	// from app
	input  wire logic [`FIX_HOST_W-1:0]  connect_host_i,
	input  wire logic                    end_session_i,	// from app
	input  wire logic [`FIX_HOST_W-1:0]  end_host_i,
	input  wire logic                    rx_valid_i,	// from link
	input  wire logic [7:0]              rx_byte_i,
	input  wire logic [`FIX_HOST_W-1:0]  rx_host_i,
	input  wire logic                    fifo_full_i,
	output logic                         fifo_write_o,	// to outgoing fifo
	output logic [7:0]                   fifo_data_o,
	output logic [`FIX_HOST_W-1:0]       fifo_host_o,
	output logic                         msg_end_o,
	output logic [`FIX_NUM_HOST-1:0]     session_active_o
);

	logic        rx_msg_valid;
	fix_rx_msg_t rx_msg;
	fix_tx_req_t tx_req [`FIX_NUM_HOST];
	logic        sent [`FIX_NUM_HOST];

	fix_rx_parser i_fix_rx_parser (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.rx_valid_i  (rx_valid_i),
		.rx_byte_i   (rx_byte_i),
		.rx_host_i   (rx_host_i),
		.msg_valid_o (rx_msg_valid),
		.msg_o       (rx_msg)
	);

	for (genvar g = 0; g < `FIX_NUM_HOST; g++) begin : g_session
		logic conn_g;
		logic end_g;
		logic rx_g;

		// strobes steered to the session of their host
		assign conn_g = connect_i && (connect_host_i == `FIX_HOST_W'(g));
		assign end_g  = end_session_i && (end_host_i == `FIX_HOST_W'(g));
		assign rx_g   = rx_msg_valid && (rx_msg.host == `FIX_HOST_W'(g));

		fix_session i_fix_session (
			.clk           (clk),
			.rst_n_i       (rst_n_i),
			.rx_valid_i    (rx_g),
			.rx_msg_i      (rx_msg),
			.connect_i     (conn_g),
			.end_session_i (end_g),
			.sent_i        (sent[g]),
			.tx_req_o      (tx_req[g]),
			.active_o      (session_active_o[g])
		);
	end

	fix_tx_composer i_fix_tx_composer (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.req_i        (tx_req),
		.fifo_full_i  (fifo_full_i),
		.sent_o       (sent),
		.fifo_write_o (fifo_write_o),
		.fifo_data_o  (fifo_data_o),
		.fifo_host_o  (fifo_host_o),
		.msg_end_o    (msg_end_o)
	);

endmodule

`default_nettype wire

// File: fix_engine_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "fix_cfg.svh"

module fix_engine_tb
	import fix_pkg::*;
();

	localparam int HW = `FIX_HOST_W;
	localparam int HB = `FIX_HB_CYCLES;
	// 10 messages at worst doubled by stalls, 9 received messages with byte gaps,
	// three heartbeat waits and some slack
	localparam int WD_CYCLES = 10 * 19 * 2 + 9 * 12 * 5 + 3 * HB + 1000;

	logic                    clk;
	logic                    rst_n;
	logic                    connect;
	logic [HW-1:0]           connect_host;
	logic                    end_session;
	logic [HW-1:0]           end_host;
	logic                    rx_valid;
	logic [7:0]              rx_byte;
	logic [HW-1:0]           rx_host;
	logic                    fifo_full;
	logic                    fifo_write;
	logic [7:0]              fifo_data;
	logic [HW-1:0]           fifo_host;
	logic                    msg_end;
	logic [`FIX_NUM_HOST-1:0] session_active;

	integer     seed = 46257;
	int         cyc;
	int         err_cnt;
	int         err_at_start;
	int         pass_cnt;
	int         fail_cnt;
	string      cur_test;
	bit         stall_en;	// random fifo full
	bit         hold_full;	// fifo full held high
	logic [7:0] rx_buf [19];	// bytes of the message being collected
	int         nbytes;
	logic [HW-1:0] mon_host;
	int         exp_seq [`FIX_NUM_HOST];	// predicted next sequence number
	int         host_cnt [`FIX_NUM_HOST];
	logic [7:0] exp_type [`FIX_NUM_HOST];	// type expected next per host
	int         host_log [$];	// hosts in the order written
	int         msg_end_cyc;

	fix_engine i_fix_engine (
		.clk              (clk),
		.rst_n_i          (rst_n),
		.connect_i        (connect),
		.connect_host_i   (connect_host),
		.end_session_i    (end_session),
		.end_host_i       (end_host),
		.rx_valid_i       (rx_valid),
		.rx_byte_i        (rx_byte),
		.rx_host_i        (rx_host),
		.fifo_full_i      (fifo_full),
		.fifo_write_o     (fifo_write),
		.fifo_data_o      (fifo_data),
		.fifo_host_o      (fifo_host),
		.msg_end_o        (msg_end),
		.session_active_o (session_active)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (hold_full)
			fifo_full <= 1'b1;
		else if (stall_en)
			fifo_full <= (($random(seed) & 3) == 0);	// about one cycle in four
		else
			fifo_full <= 1'b0;
	end

	no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(fifo_write && fifo_full))
	else begin
		$display("FIFO written while full at cycle %0d", cyc);
		err_cnt++;
	end

	task automatic report_error(input string what);
		$display("Error in %s: %s", cur_test, what);
		err_cnt++;
	endtask

	task automatic check_eq(input string what, input int exp_v, input int act_v);
		assert (exp_v == act_v)
		else begin
			$display("Mismatch %s %s: expected 0x%0h, actual 0x%0h", cur_test, what,
				exp_v, act_v);
			err_cnt++;
		end
	endtask

	// expected bytes follow the outgoing format with the type expected for the host
	task automatic check_message();
		logic [7:0] e [19];
		int sum;
		int s;
		s = exp_seq[mon_host];
		e = '{8'h33, 8'h35, 8'h3d, exp_type[mon_host], 8'h01, 8'h33, 8'h34, 8'h3d,
			8'h30 + s / 100, 8'h30 + (s / 10) % 10, 8'h30 + s % 10, 8'h01,
			8'h31, 8'h30, 8'h3d, 8'h00, 8'h00, 8'h00, 8'h01};
		sum = 0;
		for (int i = 0; i < 12; i++)
			sum += e[i];
		sum = sum % 256;
		e[15] = 8'h30 + sum / 100;
		e[16] = 8'h30 + (sum / 10) % 10;
		e[17] = 8'h30 + sum % 10;
		check_eq("byte count", 19, nbytes);
		for (int i = 0; i < 19 && i < nbytes; i++)
			check_eq($sformatf("host %0d byte %0d", mon_host, i), e[i], rx_buf[i]);
		exp_seq[mon_host] = (s + 1) % 1000;	// 999 wraps to 000
		host_cnt[mon_host]++;
		host_log.push_back(mon_host);
		msg_end_cyc = cyc;
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			assert (!msg_end || fifo_write)
			else
				report_error("message end without a FIFO write");
			if (fifo_write) begin
				if (nbytes == 0)
					mon_host = fifo_host;
				check_eq("host within message", mon_host, fifo_host);
				if (nbytes < 19)
					rx_buf[nbytes] = fifo_data;
				nbytes++;
				if (msg_end) begin
					check_message();
					nbytes = 0;
				end
			end
		end
	end

	task automatic send_byte(input int h, input logic [7:0] b);
		int gap;
		gap = $random(seed) & 3;
		repeat (gap) begin
			@(posedge clk);
			rx_valid <= 1'b0;
		end
		@(posedge clk);
		rx_valid <= 1'b1;
		rx_byte  <= b;
		rx_host  <= HW'(h);
	endtask

	// "35=T" soh "10=CCC" soh with the last checksum digit flipped when bad
	task automatic send_msg(input int h, input logic [7:0] t, input bit bad);
		logic [7:0] m [12];
		int sum;
		m = '{8'h33, 8'h35, 8'h3d, t, 8'h01, 8'h31, 8'h30, 8'h3d, 8'h00, 8'h00, 8'h00, 8'h01};
		sum = (m[0] + m[1] + m[2] + m[3] + m[4]) % 256;
		m[8]  = 8'h30 + sum / 100;
		m[9]  = 8'h30 + (sum / 10) % 10;
		m[10] = 8'h30 + sum % 10;
		if (bad)
			m[10] = (m[10] == 8'h39) ? 8'h30 : m[10] + 8'd1;
		for (int i = 0; i < 12; i++)
			send_byte(h, m[i]);
		@(posedge clk);
		rx_valid <= 1'b0;
	endtask

	task automatic do_connect(input int h);
		@(posedge clk);
		connect      <= 1'b1;
		connect_host <= HW'(h);
		@(posedge clk);
		connect <= 1'b0;
	endtask

	task automatic do_end(input int h);
		@(posedge clk);
		end_session <= 1'b1;
		end_host    <= HW'(h);
		@(posedge clk);
		end_session <= 1'b0;
	endtask

	task automatic wait_host(input int h, input int cnt, input int limit);
		int t;
		t = 0;
		while (host_cnt[h] < cnt && t < limit) begin
			@(posedge clk);
			t++;
		end
		if (host_cnt[h] < cnt)
			report_error($sformatf("no message from host %0d within %0d cycles", h, limit));
	endtask

	task automatic wait_active(input int h, input bit v, input int limit);
		int t;
		t = 0;
		while (session_active[h] !== v && t < limit) begin
			@(posedge clk);
			t++;
		end
		if (session_active[h] !== v)
			report_error($sformatf("session %0d active flag did not become %0d", h, v));
	endtask

	task automatic begin_test(input string name);
		cur_test     = name;
		err_at_start = err_cnt;
	endtask

	task automatic end_test();
		if (err_cnt == err_at_start) begin
			pass_cnt++;
			$display("test %s: ok", cur_test);
		end else begin
			fail_cnt++;
			$display("test %s: failed with %0d errors", cur_test, err_cnt - err_at_start);
		end
	endtask

	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles in test %s", WD_CYCLES, cur_test);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int n;
		int t0;
		int t_rx;
		rst_n        = 1'b0;
		connect      = 1'b0;
		connect_host = '0;
		end_session  = 1'b0;
		end_host     = '0;
		rx_valid     = 1'b0;
		rx_byte      = '0;
		rx_host      = '0;
		fifo_full    = 1'b0;
		stall_en     = 1'b0;
		hold_full    = 1'b0;
		cyc          = 0;
		nbytes       = 0;
		cur_test     = "reset";
		for (int i = 0; i < `FIX_NUM_HOST; i++) begin
			exp_seq[i]  = 1;
			host_cnt[i] = 0;
			exp_type[i] = FIX_MT_LOGON;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		begin_test("logon_tx");
		stall_en <= 1'b1;
		exp_type[2] = FIX_MT_LOGON;
		do_connect(2);
		wait_host(2, 1, 400);
		end_test();

		begin_test("logon_rx");
		send_msg(2, FIX_MT_LOGON, 1'b1);
		repeat (6) @(posedge clk);	// report plus session update
		check_eq("active after bad checksum", 0, session_active[2]);
		send_msg(2, FIX_MT_LOGON, 1'b0);
		wait_active(2, 1'b1, 20);
		end_test();

		begin_test("test_request");
		n = host_cnt[2];
		exp_type[2] = FIX_MT_HEARTBEAT;
		send_msg(2, FIX_MT_TEST_REQ, 1'b0);
		wait_host(2, n + 1, 400);
		end_test();

		begin_test("heartbeat");
		stall_en <= 1'b0;
		n  = host_cnt[2];
		t0 = msg_end_cyc;
		wait_host(2, n + 1, HB + 100);
		assert (msg_end_cyc - t0 >= HB && msg_end_cyc - t0 <= HB + 40)
		else
			report_error($sformatf("heartbeat came %0d cycles after the last message",
				msg_end_cyc - t0));
		repeat (HB / 2) @(posedge clk);
		send_msg(2, FIX_MT_HEARTBEAT, 1'b0);
		t_rx = cyc;
		n    = host_cnt[2];
		wait_host(2, n + 1, HB + 100);
		assert (msg_end_cyc - t_rx >= HB)
		else
			report_error("heartbeat not put off by the received message");
		end_test();

		begin_test("round_robin");
		hold_full <= 1'b1;
		exp_type[0] = FIX_MT_LOGON;
		exp_type[1] = FIX_MT_LOGON;
		exp_type[3] = FIX_MT_LOGON;
		send_msg(2, FIX_MT_TEST_REQ, 1'b0);	// host 2 granted and then stalled
		do_connect(0);
		do_connect(1);
		do_connect(3);
		repeat (4) @(posedge clk);
		n = host_log.size();
		hold_full <= 1'b0;
		stall_en  <= 1'b1;
		wait_host(1, host_cnt[1] + 1, 600);
		// the other hosts follow host 2 in turn
		if (host_log.size() >= n + 4) begin
			for (int i = 0; i < 4; i++)
				check_eq($sformatf("grant %0d", i), (2 + i) % 4, host_log[n + i]);
		end else begin
			report_error("fewer than four messages written");
		end
		for (int h = 0; h < 4; h++) begin
			if (h != 2) begin
				send_msg(h, FIX_MT_LOGON, 1'b0);
				wait_active(h, 1'b1, 20);
			end
		end
		n = host_cnt[0];
		exp_type[0] = FIX_MT_LOGOUT;
		do_end(0);
		wait_host(0, n + 1, 400);
		check_eq("host 0 active", 0, session_active[0]);
		n = host_cnt[1];
		exp_type[1] = FIX_MT_LOGOUT;
		send_msg(1, FIX_MT_LOGOUT, 1'b0);
		wait_host(1, n + 1, 400);
		check_eq("host 1 active", 0, session_active[1]);
		end_test();

		$display("tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
fix_pkg.sv
fix_rx_parser.sv
fix_session.sv
fix_tx_composer.sv
fix_engine.sv
fix_engine_tb.sv

// File: Bender.yml
package:
  name: fix_engine

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fix_pkg.sv
      - fix_rx_parser.sv
      - fix_session.sv
      - fix_tx_composer.sv
      - fix_engine.sv
  - target: test
    include_dirs:
      - .
    files:
      - fix_engine_tb.sv
